//--- rv_core.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_rv_core -f rv_core.f -Mdir obj_dir
	./obj_dir/Vtb_rv_core > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rv_core_input.txt
// program: word count, then byte address and instruction word per line, in hex
// expected: retire count, then pc, rd and written value per line, in hex
17
00 00500093     // addi x1, x0, 5
04 ff908113     // addi x2, x1, -7
08 00112193     // slti x3, x2, 1
0c 80000237     // lui  x4, 0x80000
10 001222b3     // slt  x5, x4, x1
14 40208333     // sub  x6, x1, x2
18 0f034393     // xori x7, x6, 0xf0
1c 0043e433     // or   x8, x7, x4
20 002474b3     // and  x9, x8, x2
24 00108013     // addi x0, x1, 1
28 00208463     // beq  x1, x2, +8 not taken
2c 00100533     // add  x10, x0, x1
30 00002583     // lw   x11, 0(x0) unsupported
34 00209463     // bne  x1, x2, +8 taken
38 7aa00613     // marker
3c 00150463     // beq  x10, x1, +8 taken
40 7cc00693     // marker
44 0080076f     // jal  x14, +8
48 7ee00793     // marker
4c 0f877813     // andi x16, x14, 0xf8
50 009848b3     // xor  x17, x16, x9
54 0020a933     // slt  x18, x1, x2
58 0000006f     // jal  x0, 0
0e
00 01 00000005
04 02 fffffffe
08 03 00000001
0c 04 80000000
10 05 00000001
14 06 00000007
18 07 000000f7
1c 08 800000f7
20 09 800000f6
2c 0a 00000005
44 0e 00000048
4c 10 00000048
50 11 800000be
54 12 00000000

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    // ####################################################################
    // run parameters and signals
    // ####################################################################

    localparam int    MEM_WORDS       = 1 << (rv_pkg::PC_BITS - 2);
    localparam int    FILE_WORDS      = 512;
    localparam int    CYCLES_PER_WORD = 20;
    localparam int    DRAIN_CYCLES    = 20;
    localparam string DATA_FILE       = "rv_core_input.txt";

    logic            clk    = 1'b0;
    logic            arst_n = 1'b0;
    logic            psel;
    logic            penable;
    rv_pkg::pc_t     paddr;
    rv_pkg::instr_t  prdata = '0;
    logic            pready = 1'b0;
    rv_pkg::wb_pkt_t retire;

    rv_pkg::instr_t  mem [0:MEM_WORDS-1];
    logic [31:0]     file_words [0:FILE_WORDS-1];
    rv_pkg::wb_pkt_t expected [$];
    int              n_prog    = 0;
    int              n_exp     = 0;
    int              n_matched = 0;
    int              wait_left = 0;
    integer          seed      = 32'h2ea0_4ac2;

    rv_core dut
    (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .o_psel    (psel),
        .o_penable (penable),
        .o_paddr   (paddr),
        .i_prdata  (prdata),
        .i_pready  (pready),
        .o_retire  (retire)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // ####################################################################
    // program image and expected retires
    // ####################################################################

    task automatic load_data_file();
        int              i;
        int              pos;
        rv_pkg::wb_pkt_t pkt;
        for (i = 0; i < FILE_WORDS; i++)
            file_words[i] = '1;
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = {i[15:0], 16'h0000};               // opcode zero, a bubble.
        $readmemh(DATA_FILE, file_words);
        n_prog = int'(file_words[0]);
        assert (n_prog > 0 && 2 * n_prog + 2 < FILE_WORDS)
        else report_failure("the data file holds no readable program word count");
        pos = 1;
        for (i = 0; i < n_prog; i++)
        begin
            mem[file_words[pos][rv_pkg::PC_BITS-1:2]] = file_words[pos + 1];
            pos = pos + 2;
        end
        n_exp = int'(file_words[pos]);
        pos   = pos + 1;
        assert (n_exp > 0 && pos + 3 * n_exp <= FILE_WORDS)
        else report_failure("the data file holds no readable count of expected retires");
        for (i = 0; i < n_exp; i++)
        begin
            pkt.valid = 1'b1;
            pkt.pc    = file_words[pos][rv_pkg::PC_BITS-1:0];
            pkt.rd    = file_words[pos + 1][4:0];
            pkt.data  = file_words[pos + 2];
            expected.push_back(pkt);
            pos = pos + 3;
        end
    endtask

    // ####################################################################
    // apb memory with random wait states
    // ####################################################################

    always @(posedge clk)
    begin
        #1;
        if (psel && !penable)
        begin
            wait_left = $random(seed) & 3;              // 0 to 3 wait states.
            pready    = 1'b0;
        end
        else if (psel && penable && (wait_left == 0))
        begin
            assert (paddr[1:0] == 2'b00)
            else report_failure($sformatf("[FAIL] time %0t: misaligned fetch %h", $time, paddr));
            prdata = mem[paddr[rv_pkg::PC_BITS-1:2]];
            pready = 1'b1;
        end
        else if (psel && penable)
        begin
            wait_left = wait_left - 1;
            pready    = 1'b0;
        end
        else
            pready = 1'b0;
    end

    // ####################################################################
    // retire checker
    // ####################################################################

    task automatic check_retire();
        rv_pkg::wb_pkt_t want;
        assert (n_matched < n_exp)
        else report_failure($sformatf("[FAIL] time %0t: extra retire pc %h x%0d = %h",
                                      $time, retire.pc, retire.rd, retire.data));
        if (n_matched < n_exp)
        begin
            want = expected[n_matched];
            assert (retire.pc == want.pc && retire.rd == want.rd && retire.data == want.data)
            else report_failure($sformatf(
                "[FAIL] time %0t: retire %0d got pc %h x%0d = %h, expected pc %h x%0d = %h",
                $time, n_matched, retire.pc, retire.rd, retire.data,
                want.pc, want.rd, want.data));
            n_matched = n_matched + 1;
        end
    endtask

    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            assert (!psel && !penable && !retire.valid)
            else report_failure($sformatf("[FAIL] time %0t: bus or retire active in reset",
                                          $time));
        end
        else if (retire.valid)
            check_retire();
    end

    // ####################################################################
    // run control and watchdog
    // ####################################################################

    initial
    begin
        load_data_file();
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (n_matched < n_exp)
            @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);           // any late retire fails.
        $display("TESTS PASSED");
        $finish;
    end

    initial
    begin
        @(posedge arst_n);
        repeat (n_prog * CYCLES_PER_WORD) @(posedge clk);
        report_failure($sformatf("retirement stalled, %0d of %0d expected retires seen",
                                 n_matched, n_exp));
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core
(
    input  wire                 i_clk,
    input  wire                 i_arst_n,
    output logic                o_psel,
    output logic                o_penable,
    output rv_pkg::pc_t         o_paddr,
    input  rv_pkg::instr_t      i_prdata,
    input  wire                 i_pready,
    output rv_pkg::wb_pkt_t     o_retire
);

    rv_pkg::fetch_pkt_t  fetch_pkt;
    rv_pkg::decode_pkt_t decode_pkt;
    rv_pkg::redirect_t   redirect;
    rv_pkg::wb_pkt_t     wb;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    rv_pkg::word_t       rs1_data;
    rv_pkg::word_t       rs2_data;

    rv_fetch u_fetch
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_redirect (redirect),
        .o_psel     (o_psel),
        .o_penable  (o_penable),
        .o_paddr    (o_paddr),
        .i_prdata   (i_prdata),
        .i_pready   (i_pready),
        .o_fetch    (fetch_pkt)
    );

    rv_decode u_decode
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_fetch    (fetch_pkt),
        .i_redirect (redirect),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_decode   (decode_pkt)
    );

    rv_regs u_regs
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_wb       (wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_execute u_execute
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_decode   (decode_pkt),
        .o_redirect (redirect),
        .o_wb       (wb)
    );

    assign o_retire = wb;                               // writeback is the retire port.

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  rv_pkg::decode_pkt_t  i_decode,
    output rv_pkg::redirect_t    o_redirect,
    output rv_pkg::wb_pkt_t      o_wb
);

    rv_pkg::word_t   src1;
    rv_pkg::word_t   src2;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   alu_res;
    rv_pkg::word_t   link;
    rv_pkg::pc_t     pc_plus4;
    rv_pkg::pc_t     target;
    logic            equal;
    logic            taken;
    rv_pkg::wb_pkt_t wb_q;

    // ####################################################################
    // forwarding from the writeback register
    // ####################################################################

    always_comb
    begin
        src1 = i_decode.rs1_data;
        src2 = i_decode.rs2_data;
        if (wb_q.valid && (wb_q.rd == i_decode.rs1) && !i_decode.is_lui)
            src1 = wb_q.data;                           // lui has no rs1 field.
        if (wb_q.valid && (wb_q.rd == i_decode.rs2))
            src2 = wb_q.data;
    end

    // ####################################################################
    // alu
    // ####################################################################

    assign op_b = i_decode.use_imm ? i_decode.imm : src2;

    always_comb
    begin
        case (i_decode.alu_op)
            rv_pkg::ALU_ADD:    alu_res = src1 + op_b;
            rv_pkg::ALU_SUB:    alu_res = src1 - op_b;
            rv_pkg::ALU_SLT:    alu_res = rv_pkg::word_t'($signed(src1) < $signed(op_b));
            rv_pkg::ALU_XOR:    alu_res = src1 ^ op_b;
            rv_pkg::ALU_OR:     alu_res = src1 | op_b;
            rv_pkg::ALU_AND:    alu_res = src1 & op_b;
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    // ####################################################################
    // branch resolve and redirect
    // ####################################################################

    assign pc_plus4 = i_decode.pc + rv_pkg::pc_t'(4);
    assign link     = rv_pkg::word_t'(pc_plus4);        // zero extended.
    assign target   = i_decode.pc + i_decode.imm[rv_pkg::PC_BITS-1:0];
    assign equal    = (src1 == src2);
    assign taken    = i_decode.is_branch && (i_decode.branch_ne ? !equal : equal);

    assign o_redirect.valid  = i_decode.valid && (i_decode.is_jal || taken);
    assign o_redirect.target = target;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            wb_q.valid <= 1'b0;
        else
        begin
            wb_q.valid <= i_decode.valid && i_decode.reg_write;
            wb_q.pc    <= i_decode.pc;
            wb_q.rd    <= i_decode.rd;
            wb_q.data  <= i_decode.is_jal ? link : alu_res;
        end
    end

    assign o_wb = wb_q;

endmodule

//--- rv_regs.sv
`timescale 1ns/1ps

module rv_regs
(
    input  wire                 i_clk,
    input  wire                 i_arst_n,
    input  rv_pkg::reg_idx_t    i_rs1,
    input  rv_pkg::reg_idx_t    i_rs2,
    input  rv_pkg::wb_pkt_t     i_wb,
    output rv_pkg::word_t       o_rs1_data,
    output rv_pkg::word_t       o_rs2_data
);

    rv_pkg::word_t regs_q [1:31];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end
        else if (i_wb.valid && (i_wb.rd != '0))
            regs_q[i_wb.rd] <= i_wb.data;
    end

    // write-through so decode sees a value retiring in the same cycle.
    assign o_rs1_data = (i_rs1 == '0) ? '0 :
                        (i_wb.valid && (i_wb.rd == i_rs1)) ? i_wb.data : regs_q[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 :
                        (i_wb.valid && (i_wb.rd == i_rs2)) ? i_wb.data : regs_q[i_rs2];

    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb.valid |-> (i_wb.rd != '0));

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  rv_pkg::fetch_pkt_t   i_fetch,
    input  rv_pkg::redirect_t    i_redirect,
    output rv_pkg::reg_idx_t     o_rs1,
    output rv_pkg::reg_idx_t     o_rs2,
    input  rv_pkg::word_t        i_rs1_data,
    input  rv_pkg::word_t        i_rs2_data,
    output rv_pkg::decode_pkt_t  o_decode
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv_pkg::reg_idx_t    rd;
    rv_pkg::word_t       imm_i;
    rv_pkg::word_t       imm_u;
    rv_pkg::word_t       imm_j;
    rv_pkg::word_t       imm_b;
    logic                supported;
    rv_pkg::decode_pkt_t d_next;
    rv_pkg::decode_pkt_t dec_q;

    assign opcode = i_fetch.instr[6:0];
    assign rd     = i_fetch.instr[11:7];
    assign funct3 = i_fetch.instr[14:12];
    assign o_rs1  = i_fetch.instr[19:15];
    assign o_rs2  = i_fetch.instr[24:20];
    assign funct7 = i_fetch.instr[31:25];

    assign imm_i = {{20{i_fetch.instr[31]}}, i_fetch.instr[31:20]};
    assign imm_u = {i_fetch.instr[31:12], 12'b0};
    assign imm_j = {{12{i_fetch.instr[31]}}, i_fetch.instr[19:12], i_fetch.instr[20],
                    i_fetch.instr[30:21], 1'b0};
    assign imm_b = {{20{i_fetch.instr[31]}}, i_fetch.instr[7], i_fetch.instr[30:25],
                    i_fetch.instr[11:8], 1'b0};

    always_comb
    begin
        d_next           = '0;
        supported        = 1'b1;
        d_next.pc        = i_fetch.pc;
        d_next.rs1       = o_rs1;
        d_next.rs2       = o_rs2;
        d_next.rd        = rd;
        d_next.rs1_data  = i_rs1_data;
        d_next.rs2_data  = i_rs2_data;
        d_next.alu_op    = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OPC_LUI:
            begin
                d_next.imm     = imm_u;
                d_next.alu_op  = rv_pkg::ALU_PASS_B;
                d_next.use_imm = 1'b1;
                d_next.is_lui  = 1'b1;
            end
            rv_pkg::OPC_OP_IMM:
            begin
                d_next.imm     = imm_i;
                d_next.use_imm = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD: d_next.alu_op = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLT: d_next.alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::F3_XOR: d_next.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_OR:  d_next.alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND: d_next.alu_op = rv_pkg::ALU_AND;
                    default:        supported = 1'b0;   // sltiu and shifts.
                endcase
            end
            rv_pkg::OPC_OP:
            begin
                if (funct7 == 7'b0100000 && funct3 == rv_pkg::F3_ADD)
                    d_next.alu_op = rv_pkg::ALU_SUB;
                else if (funct7 != 7'b0000000)
                    supported = 1'b0;
                else
                    case (funct3)
                        rv_pkg::F3_ADD: d_next.alu_op = rv_pkg::ALU_ADD;
                        rv_pkg::F3_SLT: d_next.alu_op = rv_pkg::ALU_SLT;
                        rv_pkg::F3_XOR: d_next.alu_op = rv_pkg::ALU_XOR;
                        rv_pkg::F3_OR:  d_next.alu_op = rv_pkg::ALU_OR;
                        rv_pkg::F3_AND: d_next.alu_op = rv_pkg::ALU_AND;
                        default:        supported = 1'b0;
                    endcase
            end
            rv_pkg::OPC_JAL:
            begin
                d_next.imm    = imm_j;
                d_next.is_jal = 1'b1;
            end
            rv_pkg::OPC_BRANCH:
            begin
                d_next.imm       = imm_b;
                d_next.is_branch = 1'b1;
                d_next.branch_ne = (funct3 == rv_pkg::F3_BNE);
                supported = (funct3 == rv_pkg::F3_BEQ) || (funct3 == rv_pkg::F3_BNE);
            end
            default: supported = 1'b0;                  // passes on as a bubble.
        endcase
        d_next.reg_write = (opcode != rv_pkg::OPC_BRANCH) && (rd != '0);
        d_next.valid     = i_fetch.valid && supported && !i_redirect.valid;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            dec_q.valid <= 1'b0;
        else
            dec_q <= d_next;
    end

    assign o_decode = dec_q;

endmodule

//--- rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
(
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  rv_pkg::redirect_t    i_redirect,
    output logic                 o_psel,
    output logic                 o_penable,
    output rv_pkg::pc_t          o_paddr,
    input  rv_pkg::instr_t       i_prdata,
    input  wire                  i_pready,
    output rv_pkg::fetch_pkt_t   o_fetch
);

    rv_pkg::fetch_state_e state_q;
    rv_pkg::pc_t          pc_q;
    rv_pkg::pc_t          paddr_q;
    logic                 discard_q;
    logic                 done;
    rv_pkg::fetch_pkt_t   fetch_q;

    assign done      = (state_q == rv_pkg::FS_ACCESS) && i_pready;
    assign o_psel    = (state_q != rv_pkg::FS_IDLE);
    assign o_penable = (state_q == rv_pkg::FS_ACCESS);
    assign o_paddr   = paddr_q;
    assign o_fetch   = fetch_q;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q       <= rv_pkg::FS_IDLE;
            pc_q          <= rv_pkg::RESET_PC;
            discard_q     <= 1'b0;
            fetch_q.valid <= 1'b0;
        end
        else
        begin
            case (state_q)
                rv_pkg::FS_IDLE:
                begin
                    state_q <= rv_pkg::FS_SETUP;
                    paddr_q <= i_redirect.valid ? i_redirect.target : pc_q;
                end
                rv_pkg::FS_SETUP:  state_q <= rv_pkg::FS_ACCESS;
                rv_pkg::FS_ACCESS: if (i_pready) state_q <= rv_pkg::FS_IDLE;
                default:           state_q <= rv_pkg::FS_IDLE;
            endcase

            if (i_redirect.valid)
                pc_q <= i_redirect.target;
            else if (done && !discard_q)
                pc_q <= pc_q + rv_pkg::pc_t'(4);

            // transfer already on the bus keeps its address, its data is dropped.
            if (done)
                discard_q <= 1'b0;
            else if (i_redirect.valid && (state_q != rv_pkg::FS_IDLE))
                discard_q <= 1'b1;

            fetch_q.valid <= done && !discard_q && !i_redirect.valid;
            fetch_q.pc    <= paddr_q;
            fetch_q.instr <= i_prdata;
        end
    end

    a_apb_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_psel && !(o_penable && i_pready)) |=> (o_psel && $stable(o_paddr)));

endmodule

//--- rv_pkg.sv
package rv_pkg;

    // ####################################################################
    // widths
    // ####################################################################

    localparam int XLEN    = 32;
    localparam int PC_BITS = 16;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [31:0]        instr_t;
    typedef logic [PC_BITS-1:0] pc_t;
    typedef logic [4:0]         reg_idx_t;

    localparam pc_t RESET_PC = '0;

    // ####################################################################
    // opcodes and function codes
    // ####################################################################

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD = 3'b000;                // also sub.
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_SETUP,
        FS_ACCESS
    } fetch_state_e;

    // ####################################################################
    // stage packets
    // ####################################################################

    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;                              // operand b is imm.
        logic     reg_write;                            // never set for x0.
        logic     is_jal;
        logic     is_branch;
        logic     branch_ne;
        logic     is_lui;
    } decode_pkt_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rd;
        word_t    data;
    } wb_pkt_t;

    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

endpackage
